// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // cache geometry
    localparam int SETS       = 16;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 8;

    // device byte address
    // bit 0 picks the byte, 0 is the low byte
    localparam int ADDR_W = 17;

    // address fields
    // word-in-line 3:1, set index 7:4, tag 16:8
    localparam int WORD_W    = 3;
    localparam int WORD_LSB  = 1;
    localparam int INDEX_W   = 4;
    localparam int INDEX_LSB = WORD_LSB + WORD_W;
    localparam int TAG_W     = ADDR_W - INDEX_LSB - INDEX_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    // way ram address is {index, word}
    localparam int RAM_AW = INDEX_W + WORD_W;

    // sdram word address is {zeros, tag, index, word}
    localparam int SDRAM_AW  = 24;
    localparam int SDRAM_PAD = SDRAM_AW - TAG_W - INDEX_W - WORD_W;

    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(LINE_WORDS - 1);

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        HIT_READ,
        HIT_WRITE,
        EVICT_WAIT,
        WRITE_BACK,
        FILL_REQ,
        FILL,
        MERGE
    } ca_state_t;

endpackage

// ==== rtl/cache_ram_if.sv ====
`timescale 1ns/1ps

// one address and write port shared by both ways, one read port per way
interface cache_ram_if;

    logic [cache_pkg::RAM_AW-1:0] address;
    logic [15:0]                  data_write;
    logic [1:0]                   byte_en;
    logic                         wr_en_w0;
    logic                         wr_en_w1;
    logic [15:0]                  q0;
    logic [15:0]                  q1;

    modport ctrl (
        output address,
        output data_write,
        output byte_en,
        output wr_en_w0,
        output wr_en_w1,
        input  q0,
        input  q1
    );

    modport ram (
        input  address,
        input  data_write,
        input  byte_en,
        input  wr_en_w0,
        input  wr_en_w1,
        output q0,
        output q1
    );

endinterface

// ==== rtl/tag_if.sv ====
`timescale 1ns/1ps

interface tag_if;

    cache_pkg::index_t lookup_index;
    cache_pkg::tag_t   lookup_tag;

    // metadata write, applied to lookup_index
    logic              upd_en;
    logic              upd_way;
    logic              upd_valid;
    logic              upd_dirty;
    cache_pkg::tag_t   upd_tag;
    logic              touch_en;
    logic              touch_way;

    // combinational lookup results
    logic              hit_w0;
    logic              hit_w1;
    logic              victim_way;
    logic              victim_dirty;
    cache_pkg::tag_t   victim_tag;

    modport ctrl (
        output lookup_index, lookup_tag,
        output upd_en, upd_way, upd_valid, upd_dirty, upd_tag,
        output touch_en, touch_way,
        input  hit_w0, hit_w1, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input  lookup_index, lookup_tag,
        input  upd_en, upd_way, upd_valid, upd_dirty, upd_tag,
        input  touch_en, touch_way,
        output hit_w0, hit_w1, victim_way, victim_dirty, victim_tag
    );

endinterface

// ==== rtl/way_ram.sv ====
`timescale 1ns/1ps

module way_ram #(
    parameter int WAY = 0
) (
    input  logic sys_clk,
    cache_ram_if.ram ram,
    input  logic way_sel
);

    logic [15:0] mem [2**cache_pkg::RAM_AW];
    logic [15:0] q;
    logic        wr_en;

    assign wr_en = way_sel ? ram.wr_en_w1 : ram.wr_en_w0;

    // byte-masked write, registered read of the old contents
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            if (ram.byte_en[0]) begin
                mem[ram.address][7:0] <= ram.data_write[7:0];
            end
            if (ram.byte_en[1]) begin
                mem[ram.address][15:8] <= ram.data_write[15:8];
            end
        end
        q <= mem[ram.address];
    end

    // each instance owns one read bus
    if (WAY == 0) begin : g_q0
        assign ram.q0 = q;
    end else begin : g_q1
        assign ram.q1 = q;
    end

endmodule

// ==== rtl/tag_store.sv ====
`timescale 1ns/1ps

module tag_store (
    input  logic sys_clk,
    input  logic reset_n,
    tag_if.store tags
);

    cache_pkg::tag_t            tag_mem [cache_pkg::WAYS][cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0] valid_q [cache_pkg::WAYS];
    logic [cache_pkg::SETS-1:0] dirty_q [cache_pkg::WAYS];
    // most recently used way per set
    logic [cache_pkg::SETS-1:0] lru_q;

    logic valid0;
    logic valid1;
    logic dirty0;
    logic dirty1;
    logic victim;

    assign valid0 = valid_q[0][tags.lookup_index];
    assign valid1 = valid_q[1][tags.lookup_index];
    assign dirty0 = dirty_q[0][tags.lookup_index];
    assign dirty1 = dirty_q[1][tags.lookup_index];

    assign tags.hit_w0 = valid0 && (tag_mem[0][tags.lookup_index] == tags.lookup_tag);
    assign tags.hit_w1 = valid1 && (tag_mem[1][tags.lookup_index] == tags.lookup_tag);

    // empty way first, then the clean one, then the least recent
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else if (dirty0 != dirty1) begin
            victim = dirty0;
        end else begin
            victim = !lru_q[tags.lookup_index];
        end
    end

    assign tags.victim_way   = victim;
    assign tags.victim_dirty = victim ? (valid1 && dirty1) : (valid0 && dirty0);
    assign tags.victim_tag   = tag_mem[victim][tags.lookup_index];

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (tags.upd_en) begin
                valid_q[tags.upd_way][tags.lookup_index] <= tags.upd_valid;
                dirty_q[tags.upd_way][tags.lookup_index] <= tags.upd_dirty;
            end
            if (tags.touch_en) begin
                lru_q[tags.lookup_index] <= tags.touch_way;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (tags.upd_en) begin
            tag_mem[tags.upd_way][tags.lookup_index] <= tags.upd_tag;
        end
    end

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic [cache_pkg::ADDR_W-1:0]     address,
    input  logic [7:0]                       data_write,
    input  logic                             read_req,
    input  logic                             write_req,
    output logic [7:0]                       data_read,
    output logic                             read_ack,
    output logic                             write_ack,
    output logic [cache_pkg::SDRAM_AW-1:0]   sdram_address,
    output logic [15:0]                      sdram_data_write,
    output logic                             sdram_read_req,
    output logic                             sdram_write_req,
    input  logic [15:0]                      sdram_data_read,
    input  logic                             sdram_read_ack,
    input  logic                             sdram_write_ack,
    tag_if.ctrl                              tags,
    cache_ram_if.ctrl                        ram
);

    cache_pkg::ca_state_t           state;
    logic [cache_pkg::ADDR_W-1:0]   req_addr;
    logic [7:0]                     req_byte;
    logic                           is_write;
    logic                           way_q;
    logic                           step;
    logic [cache_pkg::WORD_W-1:0]   cnt;
    logic                           wr_q;
    logic [cache_pkg::RAM_AW-1:0]   ram_addr_q;
    logic [15:0]                    ram_data_q;
    logic [1:0]                     ram_be_q;

    cache_pkg::index_t              req_index;
    cache_pkg::tag_t                req_tag;
    logic [cache_pkg::WORD_W-1:0]   req_word;
    logic [cache_pkg::WORD_W-1:0]   wb_next;
    logic [15:0]                    way_q_data;
    logic                           hit;
    logic                           fill_last;

    function automatic logic [7:0] pick_byte(input logic [15:0] word, input logic high);
        return high ? word[15:8] : word[7:0];
    endfunction

    assign req_index  = req_addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];
    assign req_tag    = req_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    assign req_word   = req_addr[cache_pkg::WORD_LSB +: cache_pkg::WORD_W];
    assign way_q_data = way_q ? ram.q1 : ram.q0;
    assign hit        = tags.hit_w0 | tags.hit_w1;
    assign fill_last  = (state == cache_pkg::FILL) && (cnt == cache_pkg::LAST_WORD);

    // write-back keeps the ram one word ahead of the word on the sdram bus
    assign wb_next = cnt + cache_pkg::WORD_W'(1) + cache_pkg::WORD_W'(sdram_write_ack);

    assign ram.address    = (state == cache_pkg::WRITE_BACK) ? {req_index, wb_next} : ram_addr_q;
    assign ram.data_write = ram_data_q;
    assign ram.byte_en    = ram_be_q;
    assign ram.wr_en_w0   = wr_q & ~way_q;
    assign ram.wr_en_w1   = wr_q & way_q;

    assign tags.lookup_index = req_index;
    assign tags.lookup_tag   = req_tag;
    assign tags.upd_en       = fill_last || (state == cache_pkg::HIT_WRITE)
                               || (state == cache_pkg::MERGE);
    assign tags.upd_way      = way_q;
    assign tags.upd_valid    = 1'b1;
    // a fresh fill is clean, a byte write makes it dirty
    assign tags.upd_dirty    = (state != cache_pkg::FILL);
    assign tags.upd_tag      = req_tag;
    assign tags.touch_en     = tags.upd_en || ((state == cache_pkg::HIT_READ) && step);
    assign tags.touch_way    = way_q;

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= cache_pkg::IDLE;
            read_ack        <= 1'b0;
            write_ack       <= 1'b0;
            sdram_read_req  <= 1'b0;
            sdram_write_req <= 1'b0;
            wr_q            <= 1'b0;
            is_write        <= 1'b0;
            way_q           <= 1'b0;
            step            <= 1'b0;
            cnt             <= '0;
        end else begin
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            wr_q      <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    // the request is still up in the cycle of its ack
                    if ((read_req || write_req) && !read_ack && !write_ack) begin
                        is_write <= write_req;
                        state    <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    step <= 1'b0;
                    if (hit) begin
                        way_q <= tags.hit_w1;
                        state <= is_write ? cache_pkg::HIT_WRITE : cache_pkg::HIT_READ;
                    end else begin
                        way_q <= tags.victim_way;
                        state <= tags.victim_dirty ? cache_pkg::EVICT_WAIT
                                                   : cache_pkg::FILL_REQ;
                    end
                end
                cache_pkg::HIT_READ: begin
                    // one cycle for the ram address, one for its data
                    step <= 1'b1;
                    if (step) begin
                        read_ack <= 1'b1;
                        state    <= cache_pkg::IDLE;
                    end
                end
                cache_pkg::HIT_WRITE, cache_pkg::MERGE: begin
                    wr_q      <= 1'b1;
                    write_ack <= 1'b1;
                    state     <= cache_pkg::IDLE;
                end
                cache_pkg::EVICT_WAIT: begin
                    sdram_write_req <= 1'b1;
                    cnt             <= '0;
                    state           <= cache_pkg::WRITE_BACK;
                end
                cache_pkg::WRITE_BACK: begin
                    if (sdram_write_ack) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == cache_pkg::LAST_WORD) begin
                            sdram_write_req <= 1'b0;
                            state           <= cache_pkg::FILL_REQ;
                        end
                    end
                end
                cache_pkg::FILL_REQ: begin
                    if (sdram_read_ack) begin
                        sdram_read_req <= 1'b0;
                        cnt            <= '0;
                        state          <= cache_pkg::FILL;
                    end else begin
                        sdram_read_req <= 1'b1;
                    end
                end
                cache_pkg::FILL: begin
                    wr_q <= 1'b1;
                    cnt  <= cnt + 1'b1;
                    if (!is_write && (cnt == req_word)) begin
                        read_ack <= 1'b1;
                    end
                    if (cnt == cache_pkg::LAST_WORD) begin
                        state <= is_write ? cache_pkg::MERGE : cache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        case (state)
            cache_pkg::IDLE: begin
                req_addr   <= address;
                req_byte   <= data_write;
                // word 0 of the set, ready for a write-back
                ram_addr_q <= {address[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W],
                               cache_pkg::WORD_W'(0)};
            end
            cache_pkg::LOOKUP: begin
                ram_addr_q <= hit ? {req_index, req_word}
                                  : {req_index, cache_pkg::WORD_W'(1)};
            end
            cache_pkg::HIT_READ: begin
                if (step) begin
                    data_read <= pick_byte(way_q_data, req_addr[0]);
                end
            end
            cache_pkg::HIT_WRITE, cache_pkg::MERGE: begin
                ram_addr_q <= {req_index, req_word};
                ram_data_q <= {req_byte, req_byte};
                ram_be_q   <= req_addr[0] ? 2'b10 : 2'b01;
            end
            cache_pkg::EVICT_WAIT: begin
                sdram_address    <= {cache_pkg::SDRAM_PAD'(0), tags.victim_tag, req_index,
                                     cache_pkg::WORD_W'(0)};
                sdram_data_write <= way_q_data;
            end
            cache_pkg::WRITE_BACK: begin
                if (sdram_write_ack) begin
                    sdram_address    <= sdram_address + 1'b1;
                    sdram_data_write <= way_q_data;
                end
            end
            cache_pkg::FILL_REQ: begin
                sdram_address <= {cache_pkg::SDRAM_PAD'(0), req_tag, req_index,
                                  cache_pkg::WORD_W'(0)};
            end
            cache_pkg::FILL: begin
                ram_addr_q <= {req_index, cnt};
                ram_data_q <= sdram_data_read;
                ram_be_q   <= 2'b11;
                if (cnt == req_word) begin
                    data_read <= pick_byte(sdram_data_read, req_addr[0]);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                             sys_clk,
    input  logic                             reset_n,
    input  logic [cache_pkg::ADDR_W-1:0]     address,
    input  logic [7:0]                       data_write,
    input  logic                             read_req,
    input  logic                             write_req,
    output logic [7:0]                       data_read,
    output logic                             read_ack,
    output logic                             write_ack,
    output logic [cache_pkg::SDRAM_AW-1:0]   sdram_address,
    output logic [15:0]                      sdram_data_write,
    output logic                             sdram_read_req,
    output logic                             sdram_write_req,
    input  logic [15:0]                      sdram_data_read,
    input  logic                             sdram_read_ack,
    input  logic                             sdram_write_ack
);

    cache_ram_if ram_bus ();
    tag_if       tag_bus ();

    cache_ctrl u_ctrl (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .address          (address),
        .data_write       (data_write),
        .read_req         (read_req),
        .write_req        (write_req),
        .data_read        (data_read),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack),
        .tags             (tag_bus.ctrl),
        .ram              (ram_bus.ctrl)
    );

    tag_store u_tags (
        .sys_clk (sys_clk),
        .reset_n (reset_n),
        .tags    (tag_bus.store)
    );

    way_ram #(.WAY(0)) u_way0 (
        .sys_clk (sys_clk),
        .ram     (ram_bus.ram),
        .way_sel (1'b0)
    );

    way_ram #(.WAY(1)) u_way1 (
        .sys_clk (sys_clk),
        .ram     (ram_bus.ram),
        .way_sel (1'b1)
    );

endmodule

// ==== verif/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model (
    input  logic                           sys_clk,
    input  logic [cache_pkg::SDRAM_AW-1:0] sdram_address,
    input  logic [15:0]                    sdram_data_write,
    input  logic                           sdram_read_req,
    input  logic                           sdram_write_req,
    output logic [15:0]                    sdram_data_read,
    output logic                           sdram_read_ack,
    output logic                           sdram_write_ack
);

    bit   [15:0]                    mem [2**cache_pkg::SDRAM_AW];
    integer                         seed = 98;
    int                             read_bursts = 0;
    logic [cache_pkg::SDRAM_AW-1:0] last_read_base;
    // every accepted write word, in order
    logic [cache_pkg::SDRAM_AW-1:0] wr_addr_log [$];
    logic [15:0]                    wr_data_log [$];

    // word n starts as n * 3 + 5
    initial begin
        for (int n = 0; n < 2**cache_pkg::SDRAM_AW; n++) begin
            mem[n] = 16'(n * 3 + 5);
        end
    end

    // burst read answers with one ack and then one word per cycle
    initial begin
        int                             wait_cycles;
        logic [cache_pkg::SDRAM_AW-1:0] base;
        sdram_read_ack  = 1'b0;
        sdram_data_read = '0;
        forever begin
            @(negedge sys_clk);
            if (sdram_read_req) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(negedge sys_clk);
                base           = sdram_address;
                last_read_base = base;
                read_bursts++;
                sdram_read_ack = 1'b1;
                for (int k = 0; k < cache_pkg::LINE_WORDS; k++) begin
                    @(negedge sys_clk);
                    sdram_read_ack  = 1'b0;
                    sdram_data_read = mem[base + k];
                end
            end
        end
    end

    // one word accepted per ack and acks may run back to back
    initial begin
        int wait_cycles;
        sdram_write_ack = 1'b0;
        forever begin
            @(negedge sys_clk);
            sdram_write_ack = 1'b0;
            if (sdram_write_req) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(negedge sys_clk);
                mem[sdram_address] = sdram_data_write;
                wr_addr_log.push_back(sdram_address);
                wr_data_log.push_back(sdram_data_write);
                sdram_write_ack = 1'b1;
            end
        end
    end

endmodule

// ==== verif/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

    // 200 transactions at 80 cycles each
    localparam int CYCLE_LIMIT = 200 * 80;

    logic                           sys_clk;
    logic                           reset_n;
    logic [cache_pkg::ADDR_W-1:0]   address;
    logic [7:0]                     data_write;
    logic                           read_req;
    logic                           write_req;
    logic [7:0]                     data_read;
    logic                           read_ack;
    logic                           write_ack;
    logic [cache_pkg::SDRAM_AW-1:0] sdram_address;
    logic [15:0]                    sdram_data_write;
    logic                           sdram_read_req;
    logic                           sdram_write_req;
    logic [15:0]                    sdram_data_read;
    logic                           sdram_read_ack;
    logic                           sdram_write_ack;

    // expected contents of the whole device space
    logic [7:0] ref_mem [2**cache_pkg::ADDR_W];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    integer     seed   = 98;

    cache_top uut (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .address          (address),
        .data_write       (data_write),
        .read_req         (read_req),
        .write_req        (write_req),
        .data_read        (data_read),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack)
    );

    sdram_model sdram (
        .sys_clk          (sys_clk),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles, %0d errors so far",
                     CYCLE_LIMIT, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] pattern_byte(input int a);
        logic [15:0] w;
        w = 16'((a >> 1) * 3 + 5);
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    // sdram word address of the first word in the line
    function automatic logic [23:0] line_base(input logic [16:0] a);
        return {8'h00, a[16:4], 3'b000};
    endfunction

    function automatic logic [15:0] ref_word(input int w);
        return {ref_mem[2 * w + 1], ref_mem[2 * w]};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("** Error at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic settle(input int n);
        repeat (n) @(negedge sys_clk);
    endtask

    // lat of 0 leaves the ack latency unchecked
    task automatic read_byte(input logic [16:0] a, input int lat);
        int n;
        address  = a;
        read_req = 1'b1;
        n        = 0;
        @(negedge sys_clk);
        n++;
        while (!read_ack) begin
            @(negedge sys_clk);
            n++;
        end
        read_req = 1'b0;
        check_equal("read data", data_read, ref_mem[a]);
        if (lat > 0) begin
            check_equal("read_ack latency", n, lat);
        end
        @(negedge sys_clk);
        check_equal("read_ack pulse width", read_ack, 1'b0);
    endtask

    task automatic write_byte(input logic [16:0] a, input logic [7:0] d, input int lat);
        int n;
        address    = a;
        data_write = d;
        write_req  = 1'b1;
        n          = 0;
        @(negedge sys_clk);
        n++;
        while (!write_ack) begin
            @(negedge sys_clk);
            n++;
        end
        write_req = 1'b0;
        ref_mem[a] = d;
        if (lat > 0) begin
            check_equal("write_ack latency", n, lat);
        end
        @(negedge sys_clk);
        check_equal("write_ack pulse width", write_ack, 1'b0);
    endtask

    initial begin
        logic [16:0] a1;
        logic [16:0] a2;
        logic [16:0] ta;
        logic [16:0] tb;
        logic [16:0] tc;
        logic [16:0] ra;
        int          n0;
        int          tsel;
        int          ssel;

        reset_n    = 1'b0;
        address    = '0;
        data_write = '0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        for (int i = 0; i < 2**cache_pkg::ADDR_W; i++) begin
            ref_mem[i] = pattern_byte(i);
        end
        repeat (16) @(posedge sys_clk);
        @(negedge sys_clk);

        // handshake outputs held low by reset
        check_equal("read_ack in reset", read_ack, 1'b0);
        check_equal("write_ack in reset", write_ack, 1'b0);
        check_equal("sdram_read_req in reset", sdram_read_req, 1'b0);
        check_equal("sdram_write_req in reset", sdram_write_req, 1'b0);
        reset_n = 1'b1;
        settle(2);

        // a cold read miss takes one burst from the line base
        a1 = {9'h045, 4'd3, 3'd5, 1'b1};
        read_byte(a1, 0);
        check_equal("burst reads after cold miss", sdram.read_bursts, 1);
        check_equal("burst read base", sdram.last_read_base, line_base(a1));
        settle(12);

        // read hits leave the sdram idle
        read_byte(a1 ^ 17'h6, 4);
        read_byte(a1 ^ 17'h1, 4);
        check_equal("burst reads after hits", sdram.read_bursts, 1);
        check_equal("write words after hits", sdram.wr_addr_log.size(), 0);

        // a write hit leaves the other byte of the word untouched
        write_byte(a1, 8'hc3, 3);
        read_byte(a1 ^ 17'h1, 0);
        read_byte(a1, 0);

        // write miss fills then merges
        a2 = {9'h0b7, 4'd9, 3'd2, 1'b0};
        write_byte(a2, 8'h5a, 0);
        settle(12);
        n0 = sdram.read_bursts;
        read_byte(a2, 4);
        check_equal("burst reads after merged line", sdram.read_bursts, n0);

        // LRU eviction of a dirty line in set 12
        ta = {9'h010, 4'd12, 3'd1, 1'b0};
        tb = {9'h020, 4'd12, 3'd6, 1'b1};
        tc = {9'h030, 4'd12, 3'd0, 1'b0};
        write_byte(ta, 8'h11, 0);
        write_byte(tb, 8'h22, 0);
        read_byte(ta, 0);
        n0 = sdram.wr_addr_log.size();
        read_byte(tc, 0);
        check_equal("write-back word count", sdram.wr_addr_log.size() - n0, 8);
        if (sdram.wr_addr_log.size() >= n0 + 8) begin
            for (int k = 0; k < 8; k++) begin
                check_equal("write-back address", sdram.wr_addr_log[n0 + k],
                            line_base(tb) + k);
                check_equal("write-back data", sdram.wr_data_log[n0 + k],
                            ref_word(line_base(tb) + k));
            end
        end
        settle(12);
        read_byte(tb, 0);

        // random traffic over 3 tags in 4 sets
        for (int i = 0; i < 150; i++) begin
            tsel = $unsigned($random(seed)) % 3;
            ssel = $unsigned($random(seed)) % 4;
            ra   = {9'(17 + 145 * tsel), 4'(2 + 4 * ssel), 4'($random(seed))};
            if ($random(seed) & 1) begin
                write_byte(ra, 8'($random(seed)), 0);
            end else begin
                read_byte(ra, 0);
            end
        end

        settle(4);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/cache_pkg.sv
rtl/cache_ram_if.sv
rtl/tag_if.sv
rtl/way_ram.sv
rtl/tag_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/sdram_model.sv
verif/tb_cache.sv
